// ==== design/gb_bus_pkg.sv ====
package gb_bus_pkg;

	// ------------------------------------------------------------------------
	// widths seen on the cpu side of the cartridge slot
	// ------------------------------------------------------------------------
	typedef logic [15:0] cpu_addr_t;	// full 64k cpu address space
	typedef logic [7:0]  cpu_data_t;	// one data byte

	// rom byte address into external memory, 512 banks of 16k
	typedef logic [22:0] rom_addr_t;

	// ------------------------------------------------------------------------
	// host download port
	// ------------------------------------------------------------------------
	typedef logic [24:0] dl_addr_t;	// byte address of the word being written
	typedef logic [15:0] dl_word_t;	// high byte is the odd address

	// cpu access to the cartridge
	typedef struct packed {
		logic      ce;		// cpu clock enable, one clk_sys wide
		logic      rd;		// read level
		logic      wr;		// write level
		cpu_addr_t addr;
		cpu_data_t wdata;	// byte from cpu to cart
	} cpu_bus_t;

	// rom image download
	typedef struct packed {
		logic     active;	// cartridge download is running
		logic     wr;		// one word per strobe
		dl_addr_t addr;
		dl_word_t data;
	} dl_bus_t;

endpackage

// ==== design/gb_cart_pkg.sv ====
package gb_cart_pkg;

	// ------------------------------------------------------------------------
	// cartridge header
	// ------------------------------------------------------------------------
	typedef logic [7:0] hdr_byte_t;

	// byte offsets inside the rom image
	localparam logic [24:0] HDR_TYPE_OFS = 25'h146;	// cartridge type in high byte
	localparam logic [24:0] HDR_SIZE_OFS = 25'h148;	// rom size low, ram size high

	// ------------------------------------------------------------------------
	// banking
	// ------------------------------------------------------------------------
	typedef logic [8:0] rom_bank_t;	// up to 512 rom banks of 16k
	typedef logic [3:0] ram_bank_t;	// up to 16 ram banks of 8k

	// decoded mapper family, no sequencing
	typedef enum logic [2:0] {
		MBC_NONE,
		MBC_1,
		MBC_2,
		MBC_3,
		MBC_5
	} mbc_kind_e;

	// static configuration taken from the header
	typedef struct packed {
		mbc_kind_e mbc_kind;
		rom_bank_t rom_mask;	// mirrors rom banks beyond the rom size
		ram_bank_t ram_mask;	// mirrors ram banks beyond the ram size
	} cart_cfg_t;

	// mapper registers as written by the cpu
	typedef struct packed {
		rom_bank_t rom_bank;
		ram_bank_t ram_bank;
		logic      mbc1_mode;	// 1 = ram banking mode
		logic      rtc_sel;	// mbc3 rtc register mapped instead of ram
		logic      ram_enable;
	} bank_state_t;

endpackage

// ==== design/cart_header_capture.sv ====
`timescale 1ns/100ps

module cart_header_capture
	import gb_bus_pkg::*;
	import gb_cart_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  dl_bus_t   dl_i,
	output cart_cfg_t cfg_o
);

	hdr_byte_t type_q;	// cartridge type byte
	hdr_byte_t rom_size_q;
	hdr_byte_t ram_size_q;

	mbc_kind_e kind;
	rom_bank_t rom_mask;
	ram_bank_t ram_mask;

	// snoop the header words while the rom image streams in
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_q     <= '0;	// decodes as no mapper
			rom_size_q <= '0;
			ram_size_q <= '0;
		end else if (dl_i.active && dl_i.wr) begin
			if (dl_i.addr == HDR_TYPE_OFS)
				type_q <= dl_i.data[15:8];	// 147h is the odd byte
			if (dl_i.addr == HDR_SIZE_OFS) begin
				rom_size_q <= dl_i.data[7:0];
				ram_size_q <= dl_i.data[15:8];
			end
		end
	end

	// ------------------------------------------------------------------------
	// header decode
	// ------------------------------------------------------------------------
	always_comb begin
		unique case (type_q) inside
			[8'd1:8'd3]:   kind = MBC_1;
			[8'd5:8'd6]:   kind = MBC_2;	// 4 bit internal ram
			[8'd15:8'd19]: kind = MBC_3;
			[8'd25:8'd30]: kind = MBC_5;
			default:       kind = MBC_NONE;	// plain 32k rom or unsupported
		endcase

		// size code n means 2^(n+1) banks
		if (rom_size_q inside {[8'd1:8'd8]}) begin
			for (int i = 0; i < 9; i++)
				rom_mask[i] = (i <= int'(rom_size_q));
		end else begin
			rom_mask = 9'h07F;	// odd sizes like 52h..54h fall back to 128 banks
		end

		case (ram_size_q)
			8'd0, 8'd1, 8'd2: ram_mask = 4'b0000;	// none, 2k or a single 8k bank
			8'd3:             ram_mask = 4'b0011;	// 32k in 4 banks
			default:          ram_mask = 4'b1111;	// 128k in 16 banks
		endcase
	end

	assign cfg_o = '{mbc_kind: kind, rom_mask: rom_mask, ram_mask: ram_mask};

endmodule

// ==== design/mbc_bank_regs.sv ====
`timescale 1ns/100ps

module mbc_bank_regs
	import gb_bus_pkg::*;
	import gb_cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  cpu_bus_t    cpu_i,
	input  cart_cfg_t   cfg_i,
	output bank_state_t bank_o
);

	logic      reg_wr;	// cpu write into the rom area 0000-7fff
	logic      is_mbc1;
	logic      is_mbc3;
	logic      is_mbc5;
	cpu_data_t d;

	assign reg_wr  = cpu_i.ce && cpu_i.wr && !cpu_i.addr[15];
	assign is_mbc1 = (cfg_i.mbc_kind == MBC_1);
	assign is_mbc3 = (cfg_i.mbc_kind == MBC_3);
	assign is_mbc5 = (cfg_i.mbc_kind == MBC_5);
	assign d       = cpu_i.wdata;

	// ------------------------------------------------------------------------
	// control registers, address bits 14..13 select the register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bank_o.rom_bank   <= 9'd1;	// bank 0 is never switched in
			bank_o.ram_bank   <= '0;
			bank_o.mbc1_mode  <= 1'b0;
			bank_o.rtc_sel    <= 1'b0;
			bank_o.ram_enable <= 1'b0;
		end else if (reg_wr) begin
			case (cpu_i.addr[14:13])
				2'b00: begin	// 0000-1fff ram enable
					bank_o.ram_enable <= (d[3:0] == 4'hA);	// only ah unlocks
				end

				2'b01: begin	// 2000-3fff rom bank
					if (is_mbc5) begin
						if (cpu_i.addr[12])
							bank_o.rom_bank[8] <= d[0];	// 3000-3fff high bit
						else
							bank_o.rom_bank[7:0] <= d;	// 2000-2fff low byte
					end else if (d[6:0] == 7'd0) begin
						bank_o.rom_bank <= 9'd1;	// 0 reads as 1 on mbc1-3
					end else begin
						bank_o.rom_bank <= {2'b00, d[6:0]};
					end
				end

				2'b10: begin	// 4000-5fff ram bank or rtc select
					if (is_mbc3) begin
						if (d[3]) begin
							bank_o.rtc_sel <= 1'b1;	// rtc register selected
						end else begin
							bank_o.rtc_sel  <= 1'b0;
							bank_o.ram_bank <= {2'b00, d[1:0]};
						end
					end else if (is_mbc5) begin
						bank_o.ram_bank <= d[3:0];	// 16 banks
					end else begin
						bank_o.ram_bank <= {2'b00, d[1:0]};	// mbc1 upper bits too
					end
				end

				default: begin	// 6000-7fff banking mode
					if (is_mbc1)
						bank_o.mbc1_mode <= d[0];
				end
			endcase
		end
	end

endmodule

// ==== design/mbc_addr_map.sv ====
`timescale 1ns/100ps

module mbc_addr_map
	import gb_bus_pkg::*;
	import gb_cart_pkg::*;
#(
	parameter int CRAM_BANK_W = 4
) (
	input  cpu_bus_t                    cpu_i,
	input  logic                        dl_active_i,
	input  cart_cfg_t                   cfg_i,
	input  bank_state_t                 bank_i,
	output rom_addr_t                   rom_addr_o,
	output logic                        rom_rd_o,
	output logic [CRAM_BANK_W+12:0]     cram_addr_o,
	output logic                        cram_we_o
);

	rom_bank_t eff_rom_bank;	// after mode select and mirroring
	ram_bank_t eff_ram_bank;
	logic      in_cram;	// a000-bfff window

	// ------------------------------------------------------------------------
	// effective banks
	// ------------------------------------------------------------------------
	always_comb begin
		unique case (cfg_i.mbc_kind)
			MBC_1: begin
				// mode 0 puts the ram bank bits on rom lines 6..5
				eff_rom_bank = {2'b00, (bank_i.mbc1_mode ? 2'b00 : bank_i.ram_bank[1:0]),
				                bank_i.rom_bank[4:0]} & cfg_i.rom_mask;
				eff_ram_bank = bank_i.mbc1_mode ?
				               {2'b00, bank_i.ram_bank[1:0] & cfg_i.ram_mask[1:0]} : '0;
			end
			MBC_2: begin
				eff_rom_bank = {2'b00, bank_i.rom_bank[6:0]} & cfg_i.rom_mask;
				eff_ram_bank = '0;	// 512x4 internal ram
			end
			MBC_3: begin
				eff_rom_bank = {2'b00, bank_i.rom_bank[6:0]} & cfg_i.rom_mask;
				eff_ram_bank = {2'b00, bank_i.ram_bank[1:0] & cfg_i.ram_mask[1:0]};
			end
			MBC_5: begin
				eff_rom_bank = bank_i.rom_bank & cfg_i.rom_mask;	// all 9 bits
				eff_ram_bank = bank_i.ram_bank & cfg_i.ram_mask;
			end
			default: begin
				eff_rom_bank = '0;
				eff_ram_bank = '0;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// rom side
	// ------------------------------------------------------------------------
	always_comb begin
		if (cfg_i.mbc_kind == MBC_NONE)
			rom_addr_o = {8'd0, cpu_i.addr[14:0]};	// flat 32k
		else if (cpu_i.addr[15:14] == 2'b01)
			rom_addr_o = {eff_rom_bank, cpu_i.addr[13:0]};	// switchable 4000-7fff
		else
			rom_addr_o = {9'd0, cpu_i.addr[13:0]};	// fixed bank 0
	end

	// memory is busy with the image while a download runs
	assign rom_rd_o = cpu_i.rd && !cpu_i.addr[15] && !dl_active_i;

	// ------------------------------------------------------------------------
	// cartridge ram side
	// ------------------------------------------------------------------------
	assign in_cram     = (cpu_i.addr[15:13] == 3'b101);
	assign cram_addr_o = {eff_ram_bank[CRAM_BANK_W-1:0], cpu_i.addr[12:0]};
	assign cram_we_o   = cpu_i.ce && cpu_i.wr && in_cram;	// ram_enable not checked

endmodule

// ==== design/cart_ram.sv ====
`timescale 1ns/100ps

module cart_ram
	import gb_bus_pkg::*;
	import gb_cart_pkg::*;
#(
	parameter int CRAM_BANK_W = 4
) (
	input  logic                    clk_sys,
	input  logic [CRAM_BANK_W+12:0] cram_addr_i,
	input  logic                    cram_we_i,
	input  cpu_data_t               wdata_i,
	input  cart_cfg_t               cfg_i,
	input  bank_state_t             bank_i,
	output cpu_data_t               rdata_o
);

	localparam int DEPTH = 2 ** (CRAM_BANK_W + 13);	// 8k per bank

	cpu_data_t mem [DEPTH];
	cpu_data_t ram_q;	// raw byte, one cycle after the address

	logic en_q;	// ram_enable seen with the address
	logic nib_q;	// mbc2 nibble window a000-a1ff
	logic rtc_q;	// mbc3 rtc mapped

	// single port array, old data on read during write
	always_ff @(posedge clk_sys) begin
		if (cram_we_i)
			mem[cram_addr_i] <= wdata_i;
		ram_q <= mem[cram_addr_i];
	end

	// masking conditions travel with the read
	always_ff @(posedge clk_sys) begin
		en_q  <= bank_i.ram_enable;
		nib_q <= (cfg_i.mbc_kind == MBC_2) && (cram_addr_i[12:9] == 4'd0);
		rtc_q <= bank_i.rtc_sel;
	end

	// ------------------------------------------------------------------------
	// read data, first match wins
	// ------------------------------------------------------------------------
	always_comb begin
		if (!en_q)
			rdata_o = 8'hFF;	// locked ram floats high
		else if (nib_q)
			rdata_o = {4'hF, ram_q[3:0]};	// only the low nibble exists
		else if (rtc_q)
			rdata_o = 8'h00;	// rtc registers not modelled
		else
			rdata_o = ram_q;
	end

endmodule

// ==== design/gb_cart_mapper.sv ====
`timescale 1ns/100ps

module gb_cart_mapper
	import gb_bus_pkg::*;
	import gb_cart_pkg::*;
#(
	parameter int CRAM_BANK_W = 4	// 16 banks of 8k
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_bus_t  cpu_i,
	input  dl_bus_t   dl_i,
	output rom_addr_t rom_addr_o,
	output logic      rom_rd_o,
	output cpu_data_t cram_rdata_o
);

	cart_cfg_t   cfg;	// static, from the header
	bank_state_t bank;	// live mapper registers

	logic [CRAM_BANK_W+12:0] cram_addr;
	logic                    cram_we;

	// ------------------------------------------------------------------------
	// header snoop, mapper registers, address map, ram
	// ------------------------------------------------------------------------
	cart_header_capture i_hdr (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl_i    (dl_i),
		.cfg_o   (cfg)
	);

	mbc_bank_regs i_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu_i   (cpu_i),
		.cfg_i   (cfg),
		.bank_o  (bank)
	);

	mbc_addr_map #(.CRAM_BANK_W(CRAM_BANK_W)) i_map (
		.cpu_i       (cpu_i),
		.dl_active_i (dl_i.active),	// rom reads blocked during download
		.cfg_i       (cfg),
		.bank_i      (bank),
		.rom_addr_o  (rom_addr_o),
		.rom_rd_o    (rom_rd_o),
		.cram_addr_o (cram_addr),
		.cram_we_o   (cram_we)
	);

	cart_ram #(.CRAM_BANK_W(CRAM_BANK_W)) i_cram (
		.clk_sys     (clk_sys),
		.cram_addr_i (cram_addr),
		.cram_we_i   (cram_we),
		.wdata_i     (cpu_i.wdata),
		.cfg_i       (cfg),
		.bank_i      (bank),
		.rdata_o     (cram_rdata_o)
	);

endmodule

// ==== verification/gb_cart_mapper_sva.sv ====
`timescale 1ns/100ps

module gb_cart_mapper_sva
	import gb_bus_pkg::*;
	import gb_cart_pkg::*;
(
	input logic        clk_sys,
	input logic        reset,
	input cpu_bus_t    cpu_i,
	input dl_bus_t     dl_i,
	input bank_state_t bank_i,	// live mapper registers inside the top level
	input logic        rom_rd_o,
	input cpu_data_t   cram_rdata_o
);

	// rom strobe only for 0000-7fff and never while the image loads
	a_rom_rd_window: assert property (@(posedge clk_sys) disable iff (reset)
		rom_rd_o |-> (!cpu_i.addr[15] && !dl_i.active))
		else $error("rom_rd_o high outside 0000-7fff or during a download");

	// locked ram reads ffh one cycle later
	a_ram_locked: assert property (@(posedge clk_sys) disable iff (reset)
		!bank_i.ram_enable |=> (cram_rdata_o == 8'hFF))
		else $error("cram_rdata_o not ffh after a cycle with ram_enable off");

endmodule

bind gb_cart_mapper gb_cart_mapper_sva i_sva (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.cpu_i        (cpu_i),
	.dl_i         (dl_i),
	.bank_i       (bank),
	.rom_rd_o     (rom_rd_o),
	.cram_rdata_o (cram_rdata_o)
);

// ==== verification/tb_gb_cart_mapper.sv ====
`timescale 1ns/100ps

module tb_gb_cart_mapper
	import gb_bus_pkg::*;
	import gb_cart_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int N_HDR  = 15;	// header downloads, three per family
	localparam int N_BANK = 40;	// rom bank writes per mapper kind
	localparam int N_MODE = 20;
	localparam int N_RAM  = 80;	// ram ops per mapper kind
	localparam int N_GATE = 100;

	// reset, header download and one ram unlock
	localparam int SETUP_CYC = RESET_CYCLES + 1 + 19 + 1;
	localparam int TOTAL_CYC = N_HDR * (SETUP_CYC + 3) + 4 * (SETUP_CYC + N_BANK * 3)
		+ (SETUP_CYC + N_MODE * 7) + (SETUP_CYC + 12) + 4 * (SETUP_CYC + N_RAM * 2)
		+ (SETUP_CYC + N_GATE * 2) + 2;

	logic      clk_sys = 1'b0;
	logic      reset;
	cpu_bus_t  cpu;
	dl_bus_t   dl;
	rom_addr_t rom_addr;
	logic      rom_rd;
	cpu_data_t cram_rdata;

	logic [31:0] rng;	// xorshift state
	int          n_checks;
	int          n_errors;

	// ------------------------------------------------------------------------
	// reference model state
	// ------------------------------------------------------------------------
	int         m_kind;	// 0 none, else 1, 2, 3 or 5
	logic [8:0] m_rom_mask;
	logic [3:0] m_ram_mask;
	logic [8:0] m_rom_bank;
	logic [3:0] m_ram_bank;
	logic       m_mode;
	logic       m_rtc;
	logic       m_ram_en;
	logic [7:0] m_ram [131072];	// 16 banks of 8k
	bit         m_valid [131072];	// cell written at least once

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	gb_cart_mapper #(.CRAM_BANK_W(4)) i_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_i        (cpu),
		.dl_i         (dl),
		.rom_addr_o   (rom_addr),
		.rom_rd_o     (rom_rd),
		.cram_rdata_o (cram_rdata)
	);

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic int kind_of(input logic [7:0] t);
		if (t >= 8'd1 && t <= 8'd3) return 1;
		if (t >= 8'd5 && t <= 8'd6) return 2;
		if (t >= 8'd15 && t <= 8'd19) return 3;
		if (t >= 8'd25 && t <= 8'd30) return 5;
		return 0;
	endfunction

	function automatic logic [8:0] rom_mask_of(input logic [7:0] s);
		if (s >= 8'd1 && s <= 8'd8)
			return 9'((32'd1 << (int'(s) + 1)) - 1);	// size+1 low ones
		return 9'h07F;
	endfunction

	function automatic logic [3:0] ram_mask_of(input logic [7:0] s);
		if (s == 8'd3) return 4'h3;
		if (s <= 8'd2) return 4'h0;
		return 4'hF;
	endfunction

	// family 0..3 is mbc1, mbc2, mbc3, mbc5; anything else an unknown type
	function automatic logic [7:0] random_type(input int family);
		logic [7:0] t;
		case (family)
			0: t = 8'(1 + next_random() % 3);
			1: t = 8'(5 + next_random() % 2);
			2: t = 8'(15 + next_random() % 5);
			3: t = 8'(25 + next_random() % 6);
			default: begin
				t = 8'(next_random());
				while (kind_of(t) != 0)
					t = 8'(next_random());
			end
		endcase
		return t;
	endfunction

	function automatic logic [7:0] random_rom_size();
		int r;
		r = int'(next_random() % 11);
		return (r == 10) ? 8'h52 : 8'(r);	// 52h is an odd size code
	endfunction

	function automatic int eff_rom_bank();
		int b;
		case (m_kind)
			1: b = (m_mode ? 0 : int'(m_ram_bank[1:0])) * 32 + int'(m_rom_bank[4:0]);
			2, 3: b = int'(m_rom_bank[6:0]);
			5: b = int'(m_rom_bank);
			default: b = 0;
		endcase
		return b & int'(m_rom_mask);
	endfunction

	function automatic int eff_ram_bank();
		case (m_kind)
			1: return m_mode ? int'(m_ram_bank[1:0] & m_ram_mask[1:0]) : 0;
			3: return int'(m_ram_bank[1:0] & m_ram_mask[1:0]);
			5: return int'(m_ram_bank & m_ram_mask);
			default: return 0;
		endcase
	endfunction

	function automatic int ram_index(input logic [15:0] a);
		return eff_ram_bank() * 8192 + int'(a) % 8192;
	endfunction

	function automatic logic [22:0] exp_rom_addr(input logic [15:0] a);
		if (m_kind == 0) return 23'(int'(a) % 32768);	// flat 32k
		if (a >= 16'h4000 && a < 16'h8000)
			return 23'(eff_rom_bank() * 16384 + int'(a) % 16384);
		return 23'(int'(a) % 16384);
	endfunction

	// bit 8 says whether the byte is known
	function automatic logic [8:0] exp_ram_read(input logic [15:0] a);
		int idx;
		idx = ram_index(a);
		if (!m_ram_en) return {1'b1, 8'hFF};
		if (m_kind == 2 && a < 16'hA200) return {m_valid[idx], 4'hF, m_ram[idx][3:0]};
		if (m_rtc) return {1'b1, 8'h00};
		return {m_valid[idx], m_ram[idx]};
	endfunction

	// cpu write as seen by the mapper registers and the ram
	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		if (a < 16'h2000) begin
			m_ram_en = (d[3:0] == 4'hA);
		end else if (a < 16'h4000) begin
			if (m_kind == 5 && a >= 16'h3000)
				m_rom_bank[8] = d[0];
			else if (m_kind == 5)
				m_rom_bank[7:0] = d;
			else
				m_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
		end else if (a < 16'h6000) begin
			if (m_kind == 3 && d[3]) begin
				m_rtc = 1'b1;
			end else if (m_kind == 3) begin
				m_rtc      = 1'b0;
				m_ram_bank = {2'b00, d[1:0]};
			end else begin
				m_ram_bank = (m_kind == 5) ? d[3:0] : {2'b00, d[1:0]};
			end
		end else if (a < 16'h8000) begin
			if (m_kind == 1)
				m_mode = d[0];
		end else if (a >= 16'hA000 && a < 16'hC000) begin
			m_ram[ram_index(a)]   = d;	// written even while locked
			m_valid[ram_index(a)] = 1'b1;
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] want,
		input logic [31:0] got);
		n_errors++;
		$display("[FAIL] %s expected %h, got %h at %0t ns", name, want, got, $time);
	endtask

	// ------------------------------------------------------------------------
	// bus tasks, inputs change on the falling edge only
	// ------------------------------------------------------------------------
	task automatic cpu_access(input logic wr, input logic rd, input logic [15:0] a,
		input logic [7:0] d);
		logic [22:0] want_addr;
		logic        want_rd;
		@(negedge clk_sys);
		cpu.ce    = 1'b1;
		cpu.rd    = rd;
		cpu.wr    = wr;
		cpu.addr  = a;
		cpu.wdata = d;
		#(CLK_PERIOD / 4);	// combinational outputs settled, well before posedge
		want_addr = exp_rom_addr(a);
		want_rd   = rd && (a < 16'h8000) && !dl.active;
		n_checks += 2;
		if (rom_addr !== want_addr)
			report_mismatch("rom_addr_o", 32'(want_addr), 32'(rom_addr));
		if (rom_rd !== want_rd)
			report_mismatch("rom_rd_o", 32'(want_rd), 32'(rom_rd));
		if (wr)
			model_write(a, d);
	endtask

	task automatic ram_read(input logic [15:0] a);
		logic [8:0] want;
		cpu_access(1'b0, 1'b1, a, 8'h00);
		want = exp_ram_read(a);
		@(negedge clk_sys);	// registered read data
		cpu = '0;
		if (want[8]) begin
			n_checks++;
			if (cram_rdata !== want[7:0])
				report_mismatch("cram_rdata_o", 32'(want[7:0]), 32'(cram_rdata));
		end
	endtask

	task automatic apply_reset();
		@(negedge clk_sys);
		reset = 1'b1;
		cpu   = '0;
		dl    = '0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset      = 1'b0;
		m_kind     = 0;	// header registers cleared
		m_rom_mask = rom_mask_of(8'd0);
		m_ram_mask = ram_mask_of(8'd0);
		m_rom_bank = 9'd1;
		m_ram_bank = 4'd0;
		m_mode     = 1'b0;
		m_rtc      = 1'b0;
		m_ram_en   = 1'b0;
	endtask

	// words 140h..14eh of an image, header bytes at 146h and 148h
	task automatic download_header(input logic [7:0] t, input logic [7:0] rs,
		input logic [7:0] ms);
		logic [15:0] w;
		@(negedge clk_sys);
		dl.active = 1'b1;
		for (int ofs = 'h140; ofs < 'h150; ofs += 2) begin
			w = 16'(next_random());
			if (25'(ofs) == HDR_TYPE_OFS)
				w[15:8] = t;
			if (25'(ofs) == HDR_SIZE_OFS)
				w = {ms, rs};
			@(negedge clk_sys);
			dl.wr   = 1'b1;
			dl.addr = 25'(ofs);
			dl.data = w;
			@(negedge clk_sys);
			dl.wr = 1'b0;
		end
		m_kind     = kind_of(t);
		m_rom_mask = rom_mask_of(rs);
		m_ram_mask = ram_mask_of(ms);
		cpu_access(1'b0, 1'b1, 16'h4000 | 16'(next_random() % 16384), 8'h00);	// blocked
		@(negedge clk_sys);
		dl  = '0;
		cpu = '0;
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial begin
		logic [7:0]  d;
		logic [15:0] a;
		rng      = 32'd99781;
		reset    = 1'b1;
		cpu      = '0;
		dl       = '0;
		n_checks = 0;
		n_errors = 0;

		// header decode, bank 1 after reset
		for (int i = 0; i < N_HDR; i++) begin
			apply_reset();
			download_header(random_type(i % 5), random_rom_size(), 8'(next_random() % 6));
			cpu_access(1'b0, 1'b1, 16'h4000 | 16'(next_random() % 16384), 8'h00);
			cpu_access(1'b0, 1'b1, 16'(next_random() % 16384), 8'h00);
			cpu_access(1'b0, 1'b1, 16'h8000 | 16'(next_random()), 8'h00);
		end

		// rom banking per mapper kind, zero writes included
		for (int f = 0; f < 4; f++) begin
			apply_reset();
			download_header(random_type(f), random_rom_size(), 8'd0);
			for (int i = 0; i < N_BANK; i++) begin
				d = (i % 4 == 0) ? 8'h00 : 8'(next_random());
				cpu_access(1'b1, 1'b0, 16'h2000 | 16'(next_random() % 8192), d);
				cpu_access(1'b0, 1'b1, 16'h4000 | 16'(next_random() % 16384), 8'h00);
				cpu_access(1'b0, 1'b1, 16'(next_random() % 16384), 8'h00);
			end
		end

		// mbc1 mode, 128 rom banks and 4 ram banks
		apply_reset();
		download_header(8'h03, 8'd6, 8'd3);
		cpu_access(1'b1, 1'b0, 16'h0000, 8'h0A);
		for (int i = 0; i < N_MODE; i++) begin
			// four cells per bank, read back after the bank and mode change
			a = 16'hA000 | (16'(next_random()) & 16'h0003);
			cpu_access(1'b1, 1'b0, a, 8'(next_random()));
			cpu_access(1'b1, 1'b0, 16'h4000 | 16'(next_random() % 8192), 8'(next_random()));
			cpu_access(1'b1, 1'b0, 16'h6000 | 16'(next_random() % 8192), 8'(next_random()));
			cpu_access(1'b1, 1'b0, 16'h2000 | 16'(next_random() % 8192), 8'(next_random()));
			cpu_access(1'b0, 1'b1, 16'h4000 | 16'(next_random() % 16384), 8'h00);
			ram_read(a);
		end

		// ram enable on mbc5
		apply_reset();
		download_header(8'h1B, 8'd4, 8'd4);
		ram_read(16'hA123);	// locked after reset
		cpu_access(1'b1, 1'b0, 16'h0ABC, 8'h0A);
		cpu_access(1'b1, 1'b0, 16'hA123, 8'h5C);
		ram_read(16'hA123);
		cpu_access(1'b1, 1'b0, 16'h1F00, 8'h3B);
		ram_read(16'hA123);
		cpu_access(1'b1, 1'b0, 16'h0000, 8'hFA);	// high nibble ignored
		ram_read(16'hA123);

		// ram read-back, few cells so reads hit earlier writes
		for (int f = 0; f < 4; f++) begin
			apply_reset();
			download_header(random_type(f), random_rom_size(), 8'(2 + next_random() % 4));
			cpu_access(1'b1, 1'b0, 16'h0000, 8'h0A);
			for (int i = 0; i < N_RAM; i++) begin
				a = 16'hA000 | (16'(next_random()) & 16'h1203);	// in and out of a000-a1ff
				case (next_random() % 8)
					0, 1, 2: cpu_access(1'b1, 1'b0, a, 8'(next_random()));
					3, 4, 5: ram_read(a);
					6: cpu_access(1'b1, 1'b0, 16'h4000 | 16'(next_random() % 8192),
						8'(next_random()));	// bit 3 picks rtc on mbc3
					default: cpu_access(1'b1, 1'b0, 16'h6000, 8'(next_random()));
				endcase
			end
		end

		// rom strobe gating, random download level
		apply_reset();
		download_header(8'h13, random_rom_size(), 8'd3);
		for (int i = 0; i < N_GATE; i++) begin
			@(negedge clk_sys);
			dl.active = (next_random() % 4 == 0);
			cpu_access(1'b0, next_random() % 2 == 0, 16'(next_random()), 8'h00);
		end

		@(negedge clk_sys);
		dl  = '0;
		cpu = '0;
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// run length limit, twice the expected cycle count
	initial begin
		#(TOTAL_CYC * 2 * CLK_PERIOD);
		$display("watchdog expired before all tests completed");
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
design/gb_bus_pkg.sv
design/gb_cart_pkg.sv
design/cart_header_capture.sv
design/mbc_bank_regs.sv
design/mbc_addr_map.sv
design/cart_ram.sv
design/gb_cart_mapper.sv
verification/gb_cart_mapper_sva.sv
verification/tb_gb_cart_mapper.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_gb_cart_mapper
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
